/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= cordic_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "TEST RESULT: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
+incdir+sim
src/cordic_num_pkg.sv
src/cordic_ctl_pkg.sv
src/angle_fold.sv
src/cordic_rotator.sv
src/gain_comp.sv
src/tag_delay.sv
src/result_select.sv
src/cordic_top.sv
sim/cordic_tb.sv

/* sim/cordic_model.svh */
`ifndef CORDIC_MODEL_SVH
`define CORDIC_MODEL_SVH

// 32-bit xorshift with shifts 13, 17, 5
function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] r;
    r = s ^ (s << 13);
    r = r ^ (r >> 17);
    r = r ^ (r << 5);
    return r;
endfunction

// bit-exact rotation of (x, y) by binary angle a
function automatic void rotate_model(
    input  cordic_num_pkg::data_t  x,
    input  cordic_num_pkg::data_t  y,
    input  cordic_num_pkg::angle_t a,
    output cordic_num_pkg::data_t  rx,
    output cordic_num_pkg::data_t  ry
);
    cordic_num_pkg::data_t  cx;
    cordic_num_pkg::data_t  cy;
    cordic_num_pkg::data_t  tx;
    cordic_num_pkg::angle_t z;
    logic                   flip;
    cx = x;
    cy = y;
    z = a;
    flip = (a[31:30] == 2'd1) || (a[31:30] == 2'd2);  // second and third quadrant
    if (flip)
        z[31] = ~z[31];  // minus 180 deg
    for (int i = 0; i < cordic_num_pkg::ITER; i++) begin
        tx = cx;
        if (z >= 0) begin
            cx = cx - (cy >>> i);
            cy = cy + (tx >>> i);
            z = z - cordic_num_pkg::ATAN_TABLE[i];
        end else begin
            cx = cx + (cy >>> i);
            cy = cy - (tx >>> i);
            z = z + cordic_num_pkg::ATAN_TABLE[i];
        end
    end
    cx = cx >>> 1;  // halving before the gain steps
    cy = cy >>> 1;
    for (int k = 0; k < cordic_num_pkg::GAIN_STEPS; k++) begin
        if (cordic_num_pkg::GAIN_SUBTRACT[k]) begin
            cx = cx - (cx >>> cordic_num_pkg::GAIN_SHIFTS[k]);
            cy = cy - (cy >>> cordic_num_pkg::GAIN_SHIFTS[k]);
        end else begin
            cx = cx + (cx >>> cordic_num_pkg::GAIN_SHIFTS[k]);
            cy = cy + (cy >>> cordic_num_pkg::GAIN_SHIFTS[k]);
        end
    end
    rx = flip ? -cx : cx;
    ry = flip ? -cy : cy;
    if (a[29:0] == '0) begin  // axis angles are exact
        rx = (a[31:30] == 2'd0) ? x : (a[31:30] == 2'd1) ? -y : (a[31:30] == 2'd2) ? -x : y;
        ry = (a[31:30] == 2'd0) ? y : (a[31:30] == 2'd1) ? x : (a[31:30] == 2'd2) ? -y : -x;
    end
endfunction

`endif

/* sim/cordic_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cordic_tb;

    typedef cordic_num_pkg::data_t  data_t;
    typedef cordic_num_pkg::angle_t angle_t;

    localparam int LAT = cordic_ctl_pkg::TOTAL_LATENCY;
    localparam int N_CYCLES = 2 + 10 + 16 + 32 + 40 + 48;  // reset, idle, then test inputs
    localparam int WATCHDOG_CYCLES = N_CYCLES + LAT + 100;
    localparam logic [47:0] GAP_PATTERN = 48'hB38D_61F2_9C5B;
    localparam real TOL = 262144.0;  // 2**-12 in data units

    logic        i_clk;
    logic        i_reset;
    logic        i_valid;
    data_t       i_x;
    data_t       i_y;
    angle_t      i_angle;
    logic        o_valid;
    data_t       o_x;
    data_t       o_y;
    logic [31:0] rng;
    int          cyc;
    int          mismatches;
    int          failures;
    logic        mon_on;
    data_t       exp_x_q[$];
    data_t       exp_y_q[$];
    real         ref_x_q[$];
    real         ref_y_q[$];
    int          stamp_q[$];
    string       name_q[$];

    `include "cordic_model.svh"

    cordic_top i_dut (
        .i_clk(i_clk), .i_reset(i_reset), .i_valid(i_valid),
        .i_x(i_x), .i_y(i_y), .i_angle(i_angle),
        .o_valid(o_valid), .o_x(o_x), .o_y(o_y)
    );

    always #10 i_clk = ~i_clk;

    always @(posedge i_clk) cyc <= cyc + 1;

    function automatic logic [31:0] rand_word();
        rng = next_rand(rng);
        return rng;
    endfunction

    function automatic data_t rand_data();
        logic [31:0] r;
        data_t       v;
        r = rand_word();
        v = r & (cordic_num_pkg::IN_LIMIT - 1);
        return r[31] ? -v : v;
    endfunction

    function automatic angle_t rand_angle(input logic [1:0] quad);
        logic [31:0] r;
        r = rand_word();
        return {quad, r[29:1], 1'b1};  // low bit set keeps it off the axes
    endfunction

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH %s: expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH %s o_valid: expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic send(input string name, input data_t x, input data_t y, input angle_t a);
        data_t ex;
        data_t ey;
        real   th;
        rotate_model(x, y, a, ex, ey);
        th = $itor(a) * 3.14159265358979 / 2147483648.0;
        @(posedge i_clk);
        i_valid <= 1'b1;
        i_x     <= x;
        i_y     <= y;
        i_angle <= a;
        exp_x_q.push_back(ex);
        exp_y_q.push_back(ey);
        ref_x_q.push_back($itor(x) * $cos(th) - $itor(y) * $sin(th));
        ref_y_q.push_back($itor(x) * $sin(th) + $itor(y) * $cos(th));
        stamp_q.push_back(cyc + 1 + LAT);  // DUT samples on the next edge
        name_q.push_back(name);
    endtask

    task automatic send_idle();
        @(posedge i_clk);
        i_valid <= 1'b0;
        i_x     <= rand_data();  // junk that must not come out
        i_y     <= rand_data();
        i_angle <= rand_word();
    endtask

    task automatic test_reset_idle();
        repeat (10) begin
            @(negedge i_clk);
            check_flag("reset_idle", 1'b0, o_valid);
            check_data("reset_idle", '0, o_x);
            check_data("reset_idle", '0, o_y);
        end
    endtask

    task automatic test_exact_axes();
        for (int q = 0; q < 4; q++)
            repeat (4) send("exact_axes", rand_data(), rand_data(), {q[1:0], 30'd0});
    endtask

    task automatic test_random_angles();
        for (int q = 0; q < 4; q++)
            repeat (8) send("random_angles", rand_data(), rand_data(), rand_angle(q[1:0]));
    endtask

    task automatic test_burst();
        for (int i = 0; i < 40; i++)
            send("burst", rand_data(), rand_data(), rand_angle(i[1:0]));
    endtask

    task automatic test_gaps();
        for (int i = 47; i >= 0; i--) begin
            if (GAP_PATTERN[i])
                send("gaps", rand_data(), rand_data(), rand_angle(i[1:0]));
            else
                send_idle();
        end
    endtask

    task automatic wait_drain();
        int left;
        left = LAT + 10;
        while (stamp_q.size() > 0 && left > 0) begin
            @(negedge i_clk);
            left--;
        end
        if (stamp_q.size() > 0) begin
            failures++;
            $display("%0d results never came out, first from test %s", stamp_q.size(), name_q[0]);
        end
        repeat (5) @(negedge i_clk);  // watch for stray strobes
    endtask

    // compares every output cycle against the queue of expected results
    always @(negedge i_clk) begin : monitor
        logic  due;
        string nm;
        real   dx;
        real   dy;
        if (mon_on) begin
            due = (stamp_q.size() > 0) && (stamp_q[0] == cyc);
            nm = due ? name_q[0] : "idle";
            check_flag(nm, due, o_valid);
            if (due) begin
                if (o_valid === 1'b1) begin
                    check_data(nm, exp_x_q[0], o_x);
                    check_data(nm, exp_y_q[0], o_y);
                    dx = $itor(o_x) - ref_x_q[0];
                    dy = $itor(o_y) - ref_y_q[0];
                    if (dx > TOL || dx < -TOL || dy > TOL || dy < -TOL) begin
                        mismatches++;
                        $display("MISMATCH %s accuracy: expected (%f, %f) actual (%0d, %0d)",
                                 nm, ref_x_q[0], ref_y_q[0], o_x, o_y);
                    end
                end
                void'(exp_x_q.pop_front());
                void'(exp_y_q.pop_front());
                void'(ref_x_q.pop_front());
                void'(ref_y_q.pop_front());
                void'(stamp_q.pop_front());
                void'(name_q.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 20);
        $display("watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        i_clk = 1'b0;
        i_reset = 1'b0;
        i_valid = 1'b0;
        i_x = '0;
        i_y = '0;
        i_angle = '0;
        rng = 32'h1560_f474;
        cyc = 0;
        mismatches = 0;
        failures = 0;
        mon_on = 1'b0;
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b1;
        test_reset_idle();
        mon_on = 1'b1;
        test_exact_axes();
        test_random_angles();
        test_burst();
        test_gaps();
        send_idle();
        wait_drain();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/angle_fold.sv */
`timescale 1ns/1ps
`default_nettype none

module angle_fold (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_valid,
    input  cordic_num_pkg::data_t     i_x,
    input  cordic_num_pkg::data_t     i_y,
    input  cordic_num_pkg::angle_t    i_angle,
    output logic                      o_valid,
    output cordic_num_pkg::data_t     o_x,
    output cordic_num_pkg::data_t     o_y,
    output cordic_num_pkg::angle_t    o_angle,
    output cordic_ctl_pkg::fold_tag_t o_tag
);

    cordic_ctl_pkg::quadrant_t quad;
    cordic_num_pkg::angle_t    folded;
    cordic_ctl_pkg::fold_tag_t tag_c;

    assign quad = cordic_ctl_pkg::quadrant_t'(i_angle[cordic_num_pkg::ANGLE_W-1 -: 2]);

    always_comb begin
        folded = i_angle;
        tag_c.flip  = 1'b0;
        tag_c.exact = (i_angle[cordic_num_pkg::ANGLE_W-3:0] == '0);  // multiple of 90 deg
        unique case (quad)
            cordic_ctl_pkg::Q0: begin
                tag_c.byp_x = i_x;
                tag_c.byp_y = i_y;
            end
            cordic_ctl_pkg::Q1: begin
                folded[cordic_num_pkg::ANGLE_W-1] = ~i_angle[cordic_num_pkg::ANGLE_W-1];
                tag_c.flip  = 1'b1;  // minus 180 deg
                tag_c.byp_x = -i_y;
                tag_c.byp_y = i_x;
            end
            cordic_ctl_pkg::Q2: begin
                folded[cordic_num_pkg::ANGLE_W-1] = ~i_angle[cordic_num_pkg::ANGLE_W-1];
                tag_c.flip  = 1'b1;
                tag_c.byp_x = -i_x;
                tag_c.byp_y = -i_y;
            end
            cordic_ctl_pkg::Q3: begin
                tag_c.byp_x = i_y;
                tag_c.byp_y = -i_x;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            o_valid <= 1'b0;
            o_x     <= '0;
            o_y     <= '0;
            o_angle <= '0;
            o_tag   <= '0;
        end else begin
            o_valid <= i_valid;
            o_x     <= i_x;
            o_y     <= i_y;
            o_angle <= folded;  // now within +-90 deg
            o_tag   <= tag_c;
        end
    end

    // larger inputs overflow in the core before the gain steps scale them back
    a_in_range: assert property (@(posedge i_clk) disable iff (!i_reset)
        i_valid |-> (i_x <= cordic_num_pkg::IN_LIMIT) && (i_x >= -cordic_num_pkg::IN_LIMIT)
                 && (i_y <= cordic_num_pkg::IN_LIMIT) && (i_y >= -cordic_num_pkg::IN_LIMIT))
        else $error("angle_fold: input magnitude above IN_LIMIT");

endmodule

`default_nettype wire

/* src/cordic_ctl_pkg.sv */
`default_nettype none

package cordic_ctl_pkg;

    // top two bits of the binary angle
    typedef enum logic [1:0] {
        Q0 = 2'd0,  // 0 to 90 deg
        Q1 = 2'd1,  // 90 to 180 deg
        Q2 = 2'd2,  // 180 to 270 deg
        Q3 = 2'd3   // 270 to 360 deg
    } quadrant_t;

    // travels beside the arithmetic until the output stage
    typedef struct packed {
        logic                  flip;   // negate core result
        logic                  exact;  // angle on an axis
        cordic_num_pkg::data_t byp_x;
        cordic_num_pkg::data_t byp_y;
    } fold_tag_t;

    localparam int CORE_LATENCY  = cordic_num_pkg::ITER + cordic_num_pkg::GAIN_STEPS;
    localparam int TOTAL_LATENCY = CORE_LATENCY + 2;  // plus fold and output regs

endpackage

`default_nettype wire

/* src/cordic_num_pkg.sv */
`default_nettype none

package cordic_num_pkg;

    localparam int DATA_W     = 32;
    localparam int ANGLE_W    = 32;
    localparam int ITER       = 16;  // micro-rotations
    localparam int GAIN_STEPS = 7;   // shift-and-add steps after the core

    typedef logic signed [DATA_W-1:0]  data_t;   // two's complement, 1.0 = 2**30
    typedef logic signed [ANGLE_W-1:0] angle_t;  // binary angle, 2**30 = 90 deg

    // inputs above 0.5 could overflow after the CORDIC growth
    localparam data_t IN_LIMIT = 32'sh2000_0000;

    // atan(2**-i) scaled so that a full turn is 2**32, rounded
    localparam angle_t ATAN_TABLE [0:ITER-1] = '{
        32'sd536870912,  // 45 deg
        32'sd316933406,
        32'sd167458907,
        32'sd85004756,
        32'sd42667331,
        32'sd21354465,
        32'sd10679838,
        32'sd5340245,
        32'sd2670163,
        32'sd1335087,
        32'sd667544,
        32'sd333772,
        32'sd166886,
        32'sd83443,
        32'sd41722,
        32'sd20861
    };

    // 0.5 * (1+2^-3)(1+2^-4)(1+2^-6)(1+2^-9)(1-2^-10)(1-2^-11)(1-2^-14) ~ 0.60725
    localparam int GAIN_SHIFTS [0:GAIN_STEPS-1] = '{3, 4, 6, 9, 10, 11, 14};

    // bit k set: step k subtracts
    localparam logic [GAIN_STEPS-1:0] GAIN_SUBTRACT = 7'b111_0000;

endpackage

`default_nettype wire

/* src/cordic_rotator.sv */
`timescale 1ns/1ps
`default_nettype none

module cordic_rotator (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  cordic_num_pkg::data_t  i_x,
    input  cordic_num_pkg::data_t  i_y,
    input  cordic_num_pkg::angle_t i_angle,
    output cordic_num_pkg::data_t  o_x,
    output cordic_num_pkg::data_t  o_y
);

    cordic_num_pkg::data_t  x_q   [0:cordic_num_pkg::ITER-1];
    cordic_num_pkg::data_t  y_q   [0:cordic_num_pkg::ITER-1];
    cordic_num_pkg::data_t  x_nxt [0:cordic_num_pkg::ITER-1];
    cordic_num_pkg::data_t  y_nxt [0:cordic_num_pkg::ITER-1];
    cordic_num_pkg::angle_t z_q   [0:cordic_num_pkg::ITER-2];  // last stage needs no residual out
    cordic_num_pkg::angle_t z_nxt [0:cordic_num_pkg::ITER-2];

    for (genvar i = 0; i < cordic_num_pkg::ITER; i++) begin : g_stage
        cordic_num_pkg::data_t  x_in;
        cordic_num_pkg::data_t  y_in;
        cordic_num_pkg::angle_t z_in;
        logic                   neg;  // residual below zero

        if (i == 0) begin : g_first
            assign x_in = i_x;
            assign y_in = i_y;
            assign z_in = i_angle;
        end else begin : g_chain
            assign x_in = x_q[i-1];
            assign y_in = y_q[i-1];
            assign z_in = z_q[i-1];
        end

        assign neg      = z_in[cordic_num_pkg::ANGLE_W-1];
        assign x_nxt[i] = neg ? x_in + (y_in >>> i) : x_in - (y_in >>> i);
        assign y_nxt[i] = neg ? y_in - (x_in >>> i) : y_in + (x_in >>> i);

        if (i < cordic_num_pkg::ITER - 1) begin : g_resid
            assign z_nxt[i] = neg ? z_in + cordic_num_pkg::ATAN_TABLE[i]
                                  : z_in - cordic_num_pkg::ATAN_TABLE[i];
        end
    end

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            x_q <= '{default: '0};
            y_q <= '{default: '0};
            z_q <= '{default: '0};
        end else begin
            x_q <= x_nxt;  // one register per micro-rotation
            y_q <= y_nxt;
            z_q <= z_nxt;
        end
    end

    assign o_x = x_q[cordic_num_pkg::ITER-1];
    assign o_y = y_q[cordic_num_pkg::ITER-1];

endmodule

`default_nettype wire

/* src/cordic_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cordic_top (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_valid,
    input  cordic_num_pkg::data_t  i_x,
    input  cordic_num_pkg::data_t  i_y,
    input  cordic_num_pkg::angle_t i_angle,
    output logic                   o_valid,
    output cordic_num_pkg::data_t  o_x,
    output cordic_num_pkg::data_t  o_y
);

    logic                      fold_valid;
    cordic_num_pkg::data_t     fold_x;
    cordic_num_pkg::data_t     fold_y;
    cordic_num_pkg::angle_t    fold_angle;
    cordic_ctl_pkg::fold_tag_t fold_tag;
    cordic_num_pkg::data_t     rot_x;
    cordic_num_pkg::data_t     rot_y;
    cordic_num_pkg::data_t     gain_x;
    cordic_num_pkg::data_t     gain_y;
    logic                      dly_valid;
    cordic_ctl_pkg::fold_tag_t dly_tag;

    angle_fold u_fold (
        .i_clk(i_clk), .i_reset(i_reset), .i_valid(i_valid),
        .i_x(i_x), .i_y(i_y), .i_angle(i_angle),
        .o_valid(fold_valid), .o_x(fold_x), .o_y(fold_y),
        .o_angle(fold_angle), .o_tag(fold_tag)
    );

    cordic_rotator u_rot (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_x(fold_x), .i_y(fold_y), .i_angle(fold_angle),
        .o_x(rot_x), .o_y(rot_y)
    );

    gain_comp u_gain (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_x(rot_x), .i_y(rot_y),
        .o_x(gain_x), .o_y(gain_y)
    );

    tag_delay u_dly (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_valid(fold_valid), .i_tag(fold_tag),
        .o_valid(dly_valid), .o_tag(dly_tag)
    );

    result_select u_sel (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_valid(dly_valid), .i_tag(dly_tag),
        .i_x(gain_x), .i_y(gain_y),
        .o_valid(o_valid), .o_x(o_x), .o_y(o_y)
    );

endmodule

`default_nettype wire

/* src/gain_comp.sv */
`timescale 1ns/1ps
`default_nettype none

module gain_comp (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  cordic_num_pkg::data_t i_x,
    input  cordic_num_pkg::data_t i_y,
    output cordic_num_pkg::data_t o_x,
    output cordic_num_pkg::data_t o_y
);

    cordic_num_pkg::data_t gx_q   [0:cordic_num_pkg::GAIN_STEPS-1];
    cordic_num_pkg::data_t gy_q   [0:cordic_num_pkg::GAIN_STEPS-1];
    cordic_num_pkg::data_t gx_nxt [0:cordic_num_pkg::GAIN_STEPS-1];
    cordic_num_pkg::data_t gy_nxt [0:cordic_num_pkg::GAIN_STEPS-1];

    for (genvar k = 0; k < cordic_num_pkg::GAIN_STEPS; k++) begin : g_step
        cordic_num_pkg::data_t x_in;
        cordic_num_pkg::data_t y_in;

        if (k == 0) begin : g_half
            assign x_in = i_x >>> 1;  // the 0.5 factor goes first
            assign y_in = i_y >>> 1;
        end else begin : g_chain
            assign x_in = gx_q[k-1];
            assign y_in = gy_q[k-1];
        end

        if (cordic_num_pkg::GAIN_SUBTRACT[k]) begin : g_sub
            assign gx_nxt[k] = x_in - (x_in >>> cordic_num_pkg::GAIN_SHIFTS[k]);
            assign gy_nxt[k] = y_in - (y_in >>> cordic_num_pkg::GAIN_SHIFTS[k]);
        end else begin : g_add
            assign gx_nxt[k] = x_in + (x_in >>> cordic_num_pkg::GAIN_SHIFTS[k]);
            assign gy_nxt[k] = y_in + (y_in >>> cordic_num_pkg::GAIN_SHIFTS[k]);
        end
    end

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            gx_q <= '{default: '0};
            gy_q <= '{default: '0};
        end else begin
            gx_q <= gx_nxt;
            gy_q <= gy_nxt;
        end
    end

    assign o_x = gx_q[cordic_num_pkg::GAIN_STEPS-1];  // scaled by about 0.6073
    assign o_y = gy_q[cordic_num_pkg::GAIN_STEPS-1];

endmodule

`default_nettype wire

/* src/result_select.sv */
`timescale 1ns/1ps
`default_nettype none

module result_select (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_valid,
    input  cordic_ctl_pkg::fold_tag_t i_tag,
    input  cordic_num_pkg::data_t     i_x,
    input  cordic_num_pkg::data_t     i_y,
    output logic                      o_valid,
    output cordic_num_pkg::data_t     o_x,
    output cordic_num_pkg::data_t     o_y
);

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            o_valid <= 1'b0;
            o_x     <= '0;
            o_y     <= '0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin  // hold last result between items
                if (i_tag.exact) begin
                    o_x <= i_tag.byp_x;  // axis angle, skip the core
                    o_y <= i_tag.byp_y;
                end else if (i_tag.flip) begin
                    o_x <= -i_x;  // undo the 180 deg fold
                    o_y <= -i_y;
                end else begin
                    o_x <= i_x;
                    o_y <= i_y;
                end
            end
        end
    end

    // the strobe comes from a 24-deep chain through two modules
    a_valid_known: assert property (@(posedge i_clk) disable iff (!i_reset)
        !$isunknown(o_valid))
        else $error("result_select: o_valid unknown");

endmodule

`default_nettype wire

/* src/tag_delay.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_delay (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_valid,
    input  cordic_ctl_pkg::fold_tag_t i_tag,
    output logic                      o_valid,
    output cordic_ctl_pkg::fold_tag_t o_tag
);

    logic                      valid_q [0:cordic_ctl_pkg::CORE_LATENCY-1];
    cordic_ctl_pkg::fold_tag_t tag_q   [0:cordic_ctl_pkg::CORE_LATENCY-1];

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            valid_q <= '{default: 1'b0};  // no stale results after reset
            tag_q   <= '{default: '0};
        end else begin
            valid_q[0] <= i_valid;
            tag_q[0]   <= i_tag;
            for (int s = 1; s < cordic_ctl_pkg::CORE_LATENCY; s++) begin
                valid_q[s] <= valid_q[s-1];
                tag_q[s]   <= tag_q[s-1];
            end
        end
    end

    // lines up with the gain_comp output
    assign o_valid = valid_q[cordic_ctl_pkg::CORE_LATENCY-1];
    assign o_tag   = tag_q[cordic_ctl_pkg::CORE_LATENCY-1];

endmodule

`default_nettype wire
